// ==== hdl/axi_rd_defs.svh ====
`ifndef AXI_RD_DEFS_SVH
`define AXI_RD_DEFS_SVH

////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////
`define AXI_RD_ADDR_W 32
`define AXI_RD_DATA_W 64
`define AXI_RD_KEEP_W 8  // one strobe bit per data byte
`define AXI_RD_LEN_W 9   // 1 to 256 beats

////////////////////////////////////////////////////////////
// buffer depths
////////////////////////////////////////////////////////////
`define AXI_RD_DATA_DEPTH_LOG2 9  // 512 beats, two full bursts
`define AXI_RD_DESC_DEPTH_LOG2 2  // 4 queued descriptors

`endif

// ==== hdl/axi_rd_pkg.sv ====
`include "axi_rd_defs.svh"

package axi_rd_pkg;

    // arburst codes
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    // arcache memory attributes
    typedef enum logic [3:0] {
        CACHE_DEV_NB      = 4'b0000,
        CACHE_DEV_BUF     = 4'b0001,
        CACHE_NORM_NC_NB  = 4'b0010,
        CACHE_NORM_NC_BUF = 4'b0011  // normal, non-cacheable, bufferable
    } cache_e;

    // log2 of bytes per beat
    localparam logic [2:0] AXI_SIZE = 3'($clog2(`AXI_RD_DATA_W / 8));

endpackage

// ==== hdl/stream_pkg.sv ====
`include "axi_rd_defs.svh"

package stream_pkg;

    typedef enum logic [1:0] {
        IDLE = 2'd0,  // waiting for a descriptor
        LOAD = 2'd1,  // set up beat counter
        SEND = 2'd2   // beats going out
    } frame_state_e;

    // one entry per completed burst
    typedef struct packed {
        logic [`AXI_RD_LEN_W-1:0]  len;   // beat count
        logic [`AXI_RD_KEEP_W-1:0] strb;  // tkeep for the final beat
    } burst_desc_t;

endpackage

// ==== hdl/burst_desc_if.sv ====
interface burst_desc_if;

    logic                   push;   // one-cycle write pulse
    stream_pkg::burst_desc_t desc;
    logic                   full;
    logic                   pop;    // one-cycle read pulse, only when not empty
    stream_pkg::burst_desc_t head;  // valid while empty is low
    logic                   empty;

    modport producer (output push, output desc, input full);

    modport queue (
        input  push, input  desc, input  pop,
        output full, output head, output empty
    );

    modport consumer (output pop, input head, input empty);

endinterface

// ==== hdl/read_requester.sv ====
`include "axi_rd_defs.svh"

module read_requester (
    input  logic                      i_axis_clk,
    input  logic                      i_axis_rst,
    input  logic [`AXI_RD_ADDR_W-1:0] i_rd_addr,
    input  logic [`AXI_RD_LEN_W-1:0]  i_rd_len,
    input  logic [`AXI_RD_KEEP_W-1:0] i_rd_strb,
    input  logic                      i_rd_valid,
    output logic                      o_rd_ready,
    output logic                      o_rd_cpl,
    output logic [`AXI_RD_ADDR_W-1:0] o_araddr,
    output logic [7:0]                o_arlen,
    output logic [2:0]                o_arsize,
    output axi_rd_pkg::burst_e        o_arburst,
    output axi_rd_pkg::cache_e        o_arcache,
    output logic                      o_arvalid,
    input  logic                      i_arready,
    input  logic                      i_rvalid,
    input  logic                      i_rlast,
    output logic                      o_rready,
    burst_desc_if.producer            desc
);

    logic [`AXI_RD_ADDR_W-1:0] r_req_addr;
    logic [`AXI_RD_LEN_W-1:0]  r_req_len;
    logic [`AXI_RD_KEEP_W-1:0] r_req_strb;
    logic                      r_req_valid;
    logic                      w_last_beat;

    assign w_last_beat = i_rvalid && o_rready && i_rlast;

    // descriptor goes into the queue with the final beat
    assign desc.push = w_last_beat;
    assign desc.desc = '{len: r_req_len, strb: r_req_strb};

    ////////////////////////////////////////////////////////////
    // request capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_axis_clk) begin
        if (i_rd_valid) begin
            r_req_addr <= i_rd_addr;
            r_req_len  <= i_rd_len;
            r_req_strb <= i_rd_strb;  // held until the descriptor push
        end
    end

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            r_req_valid <= 1'b0;
            o_rd_ready  <= 1'b0;
            o_rd_cpl    <= 1'b0;
        end else begin
            r_req_valid <= i_rd_valid;
            o_rd_ready  <= !desc.full;
            o_rd_cpl    <= w_last_beat;  // single pulse per burst
        end
    end

    ////////////////////////////////////////////////////////////
    // address channel and rready
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_axis_clk) begin
        if (r_req_valid) begin
            o_araddr  <= r_req_addr;
            o_arlen   <= 8'(r_req_len - 1'b1);  // arlen counts beats minus one
            o_arsize  <= axi_rd_pkg::AXI_SIZE;
            o_arburst <= axi_rd_pkg::BURST_INCR;
            o_arcache <= axi_rd_pkg::CACHE_NORM_NC_BUF;
        end
    end

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            o_arvalid <= 1'b0;
            o_rready  <= 1'b0;
        end else begin
            if (o_arvalid && i_arready) begin
                o_arvalid <= 1'b0;
            end else if (r_req_valid) begin
                o_arvalid <= 1'b1;
            end

            if (w_last_beat) begin
                o_rready <= 1'b0;
            end else if (r_req_valid) begin
                o_rready <= 1'b1;  // up together with arvalid
            end
        end
    end

endmodule

// ==== hdl/rdata_fifo.sv ====
`include "axi_rd_defs.svh"

module rdata_fifo (
    input  logic                      i_axis_clk,
    input  logic                      i_axis_rst,
    input  logic [`AXI_RD_DATA_W-1:0] i_rdata,
    input  logic                      i_rvalid,
    input  logic                      i_rready,
    input  logic                      i_rd_en,
    output logic [`AXI_RD_DATA_W-1:0] o_dout,
    output logic                      o_avail
);

    localparam int DEPTH = 2 ** `AXI_RD_DATA_DEPTH_LOG2;

    logic [`AXI_RD_DATA_W-1:0]         r_mem [DEPTH];
    logic [`AXI_RD_DATA_DEPTH_LOG2-1:0] r_wr_ptr;
    logic [`AXI_RD_DATA_DEPTH_LOG2-1:0] r_rd_ptr;
    logic [`AXI_RD_DATA_DEPTH_LOG2:0]   r_count;
    logic                              w_wr;
    logic                              w_rd;

    assign w_wr    = i_rvalid && i_rready;  // every accepted R beat
    assign w_rd    = i_rd_en && o_avail;
    assign o_avail = (r_count != '0);
    assign o_dout  = r_mem[r_rd_ptr];       // show-ahead, oldest word

    always_ff @(posedge i_axis_clk) begin
        if (w_wr) begin
            r_mem[r_wr_ptr] <= i_rdata;
        end
    end

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_wr) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;  // wraps at depth
            end
            if (w_rd) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            case ({w_wr, w_rd})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

endmodule

// ==== hdl/burst_desc_fifo.sv ====
`include "axi_rd_defs.svh"

module burst_desc_fifo (
    input  logic         i_axis_clk,
    input  logic         i_axis_rst,
    burst_desc_if.queue  q
);

    localparam int DEPTH = 2 ** `AXI_RD_DESC_DEPTH_LOG2;

    stream_pkg::burst_desc_t            r_mem [DEPTH];
    logic [`AXI_RD_DESC_DEPTH_LOG2-1:0] r_wr_ptr;
    logic [`AXI_RD_DESC_DEPTH_LOG2-1:0] r_rd_ptr;
    logic [`AXI_RD_DESC_DEPTH_LOG2:0]   r_count;
    logic                               w_wr;
    logic                               w_rd;

    // push into a full queue is dropped
    assign w_wr    = q.push && !q.full;
    assign w_rd    = q.pop && !q.empty;
    assign q.full  = (r_count == DEPTH[`AXI_RD_DESC_DEPTH_LOG2:0]);
    assign q.empty = (r_count == '0);
    assign q.head  = r_mem[r_rd_ptr];

    always_ff @(posedge i_axis_clk) begin
        if (w_wr) begin
            r_mem[r_wr_ptr] <= q.desc;
        end
    end

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_wr) r_wr_ptr <= r_wr_ptr + 1'b1;
            if (w_rd) r_rd_ptr <= r_rd_ptr + 1'b1;
            case ({w_wr, w_rd})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;  // both or neither
            endcase
        end
    end

endmodule

// ==== hdl/axis_framer.sv ====
`include "axi_rd_defs.svh"

module axis_framer (
    input  logic                      i_axis_clk,
    input  logic                      i_axis_rst,
    burst_desc_if.consumer            desc,
    input  logic [`AXI_RD_DATA_W-1:0] i_data,
    input  logic                      i_avail,
    output logic                      o_rd_en,
    output logic [`AXI_RD_DATA_W-1:0] o_tdata,
    output logic [`AXI_RD_KEEP_W-1:0] o_tkeep,
    output logic                      o_tlast,
    output logic                      o_tvalid,
    input  logic                      i_tready
);

    stream_pkg::frame_state_e  r_state;
    logic [`AXI_RD_LEN_W-1:0]  r_len;
    logic [`AXI_RD_KEEP_W-1:0] r_strb;
    logic [`AXI_RD_LEN_W-1:0]  r_fetch_left;  // beats still to pull from the FIFO
    logic                      w_load;
    logic                      w_final;
    logic                      w_done;

    assign desc.pop = (r_state == stream_pkg::IDLE) && !desc.empty;

    // output register is free when empty or being taken
    assign w_load  = !o_tvalid || i_tready;
    assign o_rd_en = (r_state == stream_pkg::SEND) && (r_fetch_left != '0) && i_avail && w_load;
    assign w_final = (r_fetch_left == `AXI_RD_LEN_W'(1));
    assign w_done  = o_tvalid && i_tready && o_tlast;

    ////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            r_state      <= stream_pkg::IDLE;
            r_fetch_left <= '0;
        end else begin
            unique case (r_state)
                stream_pkg::IDLE: begin
                    if (!desc.empty) r_state <= stream_pkg::LOAD;
                end
                stream_pkg::LOAD: begin
                    r_fetch_left <= r_len;
                    r_state      <= stream_pkg::SEND;
                end
                stream_pkg::SEND: begin
                    if (o_rd_en) r_fetch_left <= r_fetch_left - 1'b1;
                    // stay until the tlast beat has left
                    if (w_done) r_state <= stream_pkg::IDLE;
                end
                default: r_state <= stream_pkg::IDLE;
            endcase
        end
    end

    // head is taken on the pop edge
    always_ff @(posedge i_axis_clk) begin
        if (desc.pop) begin
            r_len  <= desc.head.len;
            r_strb <= desc.head.strb;
        end
    end

    ////////////////////////////////////////////////////////////
    // output stage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            o_tvalid <= 1'b0;
            o_tlast  <= 1'b0;
        end else if (o_rd_en) begin
            o_tvalid <= 1'b1;
            o_tlast  <= w_final;
        end else if (i_tready) begin
            o_tvalid <= 1'b0;  // drained, nothing to refill
            o_tlast  <= 1'b0;
        end
    end

    always_ff @(posedge i_axis_clk) begin
        if (o_rd_en) begin
            o_tdata <= i_data;
            o_tkeep <= w_final ? r_strb : '1;  // strobe only on the last beat
        end
    end

endmodule

// ==== hdl/axi_to_axis_reader.sv ====
`include "axi_rd_defs.svh"

module axi_to_axis_reader (
    input  logic                      i_axis_clk,
    input  logic                      i_axis_rst,
    // request side
    input  logic [`AXI_RD_ADDR_W-1:0] i_rd_addr,
    input  logic [`AXI_RD_LEN_W-1:0]  i_rd_len,
    input  logic [`AXI_RD_KEEP_W-1:0] i_rd_strb,
    input  logic                      i_rd_valid,
    output logic                      o_rd_ready,
    output logic                      o_rd_cpl,
    // AXI read address channel
    output logic [`AXI_RD_ADDR_W-1:0] o_araddr,
    output logic [7:0]                o_arlen,
    output logic [2:0]                o_arsize,
    output axi_rd_pkg::burst_e        o_arburst,
    output axi_rd_pkg::cache_e        o_arcache,
    output logic                      o_arvalid,
    input  logic                      i_arready,
    // AXI read data channel
    input  logic [`AXI_RD_DATA_W-1:0] i_rdata,
    input  logic                      i_rvalid,
    input  logic                      i_rlast,
    output logic                      o_rready,
    // AXI-Stream out
    output logic [`AXI_RD_DATA_W-1:0] o_tdata,
    output logic [`AXI_RD_KEEP_W-1:0] o_tkeep,
    output logic                      o_tlast,
    output logic                      o_tvalid,
    input  logic                      i_tready
);

    logic [`AXI_RD_DATA_W-1:0] w_fifo_dout;
    logic                      w_fifo_avail;
    logic                      w_fifo_rd_en;

    burst_desc_if desc_bus ();

    read_requester u_requester (
        .i_axis_clk (i_axis_clk),
        .i_axis_rst (i_axis_rst),
        .i_rd_addr  (i_rd_addr),
        .i_rd_len   (i_rd_len),
        .i_rd_strb  (i_rd_strb),
        .i_rd_valid (i_rd_valid),
        .o_rd_ready (o_rd_ready),
        .o_rd_cpl   (o_rd_cpl),
        .o_araddr   (o_araddr),
        .o_arlen    (o_arlen),
        .o_arsize   (o_arsize),
        .o_arburst  (o_arburst),
        .o_arcache  (o_arcache),
        .o_arvalid  (o_arvalid),
        .i_arready  (i_arready),
        .i_rvalid   (i_rvalid),
        .i_rlast    (i_rlast),
        .o_rready   (o_rready),
        .desc       (desc_bus.producer)
    );

    // same accept condition the requester uses
    rdata_fifo u_rdata_fifo (
        .i_axis_clk (i_axis_clk),
        .i_axis_rst (i_axis_rst),
        .i_rdata    (i_rdata),
        .i_rvalid   (i_rvalid),
        .i_rready   (o_rready),
        .i_rd_en    (w_fifo_rd_en),
        .o_dout     (w_fifo_dout),
        .o_avail    (w_fifo_avail)
    );

    burst_desc_fifo u_desc_fifo (
        .i_axis_clk (i_axis_clk),
        .i_axis_rst (i_axis_rst),
        .q          (desc_bus.queue)
    );

    axis_framer u_framer (
        .i_axis_clk (i_axis_clk),
        .i_axis_rst (i_axis_rst),
        .desc       (desc_bus.consumer),
        .i_data     (w_fifo_dout),
        .i_avail    (w_fifo_avail),
        .o_rd_en    (w_fifo_rd_en),
        .o_tdata    (o_tdata),
        .o_tkeep    (o_tkeep),
        .o_tlast    (o_tlast),
        .o_tvalid   (o_tvalid),
        .i_tready   (i_tready)
    );

endmodule

// ==== verification/axi_to_axis_reader_props.sv ====
`include "axi_rd_defs.svh"

module axi_to_axis_reader_props (
    input logic                      i_axis_clk,
    input logic                      i_axis_rst,
    input logic [`AXI_RD_DATA_W-1:0] o_tdata,
    input logic [`AXI_RD_KEEP_W-1:0] o_tkeep,
    input logic                      o_tlast,
    input logic                      o_tvalid,
    input logic                      i_tready,
    input logic                      o_rd_cpl,
    input logic [`AXI_RD_ADDR_W-1:0] o_araddr,
    input logic [7:0]                o_arlen,
    input logic                      o_arvalid,
    input logic                      i_arready
);

    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // stream stall
    ////////////////////////////////////////////////////////////
    a_stall_hold: assert property (@(posedge i_axis_clk) disable iff (i_axis_rst)
        o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tkeep)
                                  && $stable(o_tlast))
        else begin
            $error("stream output changed while stalled");
            fail_count++;
        end

    // one completion pulse per burst
    a_cpl_pulse: assert property (@(posedge i_axis_clk) disable iff (i_axis_rst)
        o_rd_cpl |=> !o_rd_cpl)
        else begin
            $error("rd_cpl high for two cycles");
            fail_count++;
        end

    a_ar_drop: assert property (@(posedge i_axis_clk) disable iff (i_axis_rst)
        o_arvalid && i_arready |=> !o_arvalid)  // no repeat of an accepted address
        else begin
            $error("arvalid still high after acceptance");
            fail_count++;
        end

    // address channel waits for the slave
    a_ar_hold: assert property (@(posedge i_axis_clk) disable iff (i_axis_rst)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr) && $stable(o_arlen))
        else begin
            $error("address channel changed before acceptance");
            fail_count++;
        end

endmodule

bind axi_to_axis_reader axi_to_axis_reader_props u_props (.*);

// ==== verification/tb_axi_to_axis_reader.sv ====
`include "axi_rd_defs.svh"

module tb_axi_to_axis_reader;

    localparam int NUM_REQ = 10;  // lines in the pattern file

    logic                      i_axis_clk;
    logic                      i_axis_rst;
    logic [`AXI_RD_ADDR_W-1:0] i_rd_addr;
    logic [`AXI_RD_LEN_W-1:0]  i_rd_len;
    logic [`AXI_RD_KEEP_W-1:0] i_rd_strb;
    logic                      i_rd_valid;
    logic                      o_rd_ready;
    logic                      o_rd_cpl;
    logic [`AXI_RD_ADDR_W-1:0] o_araddr;
    logic [7:0]                o_arlen;
    logic [2:0]                o_arsize;
    axi_rd_pkg::burst_e        o_arburst;
    axi_rd_pkg::cache_e        o_arcache;
    logic                      o_arvalid;
    logic                      i_arready;
    logic [`AXI_RD_DATA_W-1:0] i_rdata;
    logic                      i_rvalid;
    logic                      i_rlast;
    logic                      o_rready;
    logic [`AXI_RD_DATA_W-1:0] o_tdata;
    logic [`AXI_RD_KEEP_W-1:0] o_tkeep;
    logic                      o_tlast;
    logic                      o_tvalid;
    logic                      i_tready;

    logic [31:0] pat_mem [3*NUM_REQ];  // address, length, strobe per request
    integer      seed;
    int          total_beats;
    int          cpl_count   = 0;
    bit          rst_done    = 1'b0;
    bit          stream_done = 1'b0;

    axi_to_axis_reader uut (.*);

    always #4 i_axis_clk = ~i_axis_clk;

    always @(negedge i_axis_clk) begin
        if (rst_done && o_rd_cpl) begin
            cpl_count++;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // request driver
    ////////////////////////////////////////////////////////////
    initial begin : main_flow
        logic [31:0] addr;
        logic [31:0] len;
        int          i;
        i_axis_clk = 1'b0;
        i_axis_rst = 1'b1;
        i_rd_addr  = '0;
        i_rd_len   = '0;
        i_rd_strb  = '0;
        i_rd_valid = 1'b0;
        i_arready  = 1'b0;
        i_rdata    = '0;
        i_rvalid   = 1'b0;
        i_rlast    = 1'b0;
        i_tready   = 1'b0;
        seed       = 32'h96f6_b3d7;
        $readmemh("verification/read_patterns.txt", pat_mem);
        total_beats = 0;
        for (i = 0; i < NUM_REQ; i++) begin
            total_beats += pat_mem[3*i+1];
        end

        repeat (3) @(negedge i_axis_clk);
        i_axis_rst = 1'b0;
        rst_done   = 1'b1;
        check_value("arvalid after reset", 0, o_arvalid);
        check_value("tvalid after reset", 0, o_tvalid);
        check_value("rd_cpl after reset", 0, o_rd_cpl);
        check_value("rready after reset", 0, o_rready);
        @(negedge i_axis_clk);
        check_value("rd_ready after reset", 1, o_rd_ready);

        for (i = 0; i < NUM_REQ; i++) begin
            while (!o_rd_ready) @(negedge i_axis_clk);
            addr       = pat_mem[3*i];
            len        = pat_mem[3*i+1];
            i_rd_addr  = addr;
            i_rd_len   = len[8:0];
            i_rd_strb  = pat_mem[3*i+2][7:0];
            i_rd_valid = 1'b1;  // single-cycle strobe
            @(negedge i_axis_clk);
            i_rd_valid = 1'b0;
            check_value("arvalid one cycle after strobe", 0, o_arvalid);
            @(negedge i_axis_clk);
            check_value("arvalid two cycles after strobe", 1, o_arvalid);
            check_value("araddr", addr, o_araddr);
            check_value("arlen", len - 1, o_arlen);
            check_value("arsize", 3, o_arsize);         // 8 bytes per beat
            check_value("arburst", 2'b01, o_arburst);   // INCR
            check_value("arcache", 4'b0011, o_arcache); // normal, bufferable
            check_value("rready with arvalid", 1, o_rready);
            @(negedge i_axis_clk);
            while (!o_rd_cpl) @(negedge i_axis_clk);
            @(negedge i_axis_clk);  // rd_ready lags the queue flag
        end

        wait (stream_done);
        @(negedge i_axis_clk);
        @(negedge i_axis_clk);
        check_value("tvalid after last frame", 0, o_tvalid);
        check_value("completion count", NUM_REQ, cpl_count);
        $display("Verification passed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // AXI slave model
    ////////////////////////////////////////////////////////////
    initial begin : axi_slave
        logic [31:0] base;
        logic [31:0] word;
        int          beats;
        int          gap;
        int          n;
        int          b;
        wait (rst_done);
        for (n = 0; n < NUM_REQ; n++) begin
            @(negedge i_axis_clk);
            while (!o_arvalid) @(negedge i_axis_clk);
            gap = $random(seed) & 3;
            repeat (gap) @(negedge i_axis_clk);
            i_arready = 1'b1;
            base      = o_araddr;
            beats     = int'(o_arlen) + 1;
            @(negedge i_axis_clk);
            i_arready = 1'b0;
            for (b = 0; b < beats; b++) begin
                gap = $random(seed) & 3;  // idle cycles between beats
                repeat (gap) @(negedge i_axis_clk);
                check_value("rready during burst", 1, o_rready);
                check_value("completion before rlast", 0, o_rd_cpl);
                word     = base + 32'(8 * b);
                i_rdata  = {word, word};
                i_rvalid = 1'b1;
                i_rlast  = (b == beats - 1);
                @(negedge i_axis_clk);
                i_rvalid = 1'b0;
                i_rlast  = 1'b0;
            end
            check_value("completion after rlast", 1, o_rd_cpl);
            check_value("rready after rlast", 0, o_rready);
        end
    end

    ////////////////////////////////////////////////////////////
    // stream sink and checker
    ////////////////////////////////////////////////////////////
    initial begin : stream_side
        logic [31:0] word;
        logic [63:0] held_data;
        logic [7:0]  held_keep;
        logic        held_last;
        logic        stalled;
        int          f;
        int          b;
        int          len;
        f       = 0;
        b       = 0;
        stalled = 1'b0;
        wait (rst_done);
        while (f < NUM_REQ) begin
            @(negedge i_axis_clk);
            if (stalled) begin  // last edge had valid without ready
                check_value("tvalid held in stall", 1, o_tvalid);
                check_value("tdata held in stall", held_data, o_tdata);
                check_value("tkeep held in stall", held_keep, o_tkeep);
                check_value("tlast held in stall", held_last, o_tlast);
            end
            i_tready = ($random(seed) & 1) != 0;
            len      = pat_mem[3*f+1];
            if (o_tvalid && i_tready) begin  // transfer on the coming edge
                word = pat_mem[3*f] + 32'(8 * b);
                check_value($sformatf("tdata frame %0d beat %0d", f, b), {word, word}, o_tdata);
                check_value($sformatf("tkeep frame %0d beat %0d", f, b),
                            (b == len - 1) ? pat_mem[3*f+2][7:0] : 8'hff, o_tkeep);
                check_value($sformatf("tlast frame %0d beat %0d", f, b), b == len - 1, o_tlast);
                b++;
                if (b == len) begin
                    f++;
                    b = 0;
                end
            end
            stalled   = o_tvalid && !i_tready;
            held_data = o_tdata;
            held_keep = o_tkeep;
            held_last = o_tlast;
        end
        stream_done = 1'b1;
    end

    initial begin : watchdog
        int limit;
        wait (rst_done);
        limit = 40 * total_beats + 1000;
        repeat (limit) @(posedge i_axis_clk);
        $display("timeout: test did not finish within %0d cycles", limit);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : assertion_monitor
        wait (uut.u_props.fail_count != 0);
        $display("a bound assertion failed, see the error above");
        $display("Verification failed");
        $fatal(1, "assertion failure");
    end

endmodule

// ==== verification/read_patterns.txt ====
// columns: burst address, beat count (1 to 256), tkeep of the final beat
// one request per line, all values hex
10000000 001 ff
20000040 004 0f
00001000 010 01
40000000 100 ff
7fff0f00 003 3f
00000008 008 80
12345670 002 03
a0000100 040 7f
ffff0e00 005 1f
00000c00 001 01

// ==== axi_to_axis_reader.f ====
+incdir+hdl
hdl/axi_rd_pkg.sv
hdl/stream_pkg.sv
hdl/burst_desc_if.sv
hdl/read_requester.sv
hdl/rdata_fifo.sv
hdl/burst_desc_fifo.sv
hdl/axis_framer.sv
hdl/axi_to_axis_reader.sv
verification/axi_to_axis_reader_props.sv
verification/tb_axi_to_axis_reader.sv

// ==== Bender.yml ====
package:
  name: axi_to_axis_reader

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axi_rd_pkg.sv
      - hdl/stream_pkg.sv
      - hdl/burst_desc_if.sv
      - hdl/read_requester.sv
      - hdl/rdata_fifo.sv
      - hdl/burst_desc_fifo.sv
      - hdl/axis_framer.sv
      - hdl/axi_to_axis_reader.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/axi_to_axis_reader_props.sv
      - verification/tb_axi_to_axis_reader.sv
